//--- dense_tests.txt
# Commands: test <name> | fill | act, wgt or bias <base> <count> <hex values>
# run <input_size> <output_size> <act_mode> <restart> then one expected hex result per channel
test bias_only
fill
act 0 4 00 00 00 00
bias 0 3 00000064 fffffff6 7fffffff
run 4 3 0 0 00000064 fffffff6 7fffffff
# Single input, mixed signs, negatives pass in ACT_NONE
test signed_single
fill
act 0 1 fd
wgt 0 4 05 fb 80 7f
bias 0 4 00000000 00000000 00000010 ffffffff
run 1 4 0 0 fffffff1 0000000f 00000190 fffffe82
# Same data, ReLU clamps the negatives
test relu_mode
run 1 4 1 0 00000000 0000000f 00000190 00000000
test signed_wide
fill
act 0 5 7f 80 02 fe 10
wgt 0 10 7f 7f 03 04 ff 80 80 f9 00 01
bias 0 2 00000005 fffffc18
run 5 2 0 0 ffffff74 fffffc9a
# Second start at cycle 3 with other sizes and mode
test ignored_start
fill
act 0 4 01 02 03 04
wgt 0 12 01 01 01 01 ff ff ff ff 02 00 00 fe
bias 0 3 00000000 00000000 00000064
run 4 3 0 1 0000000a fffffff6 0000005e
# New weights only, activations and biases kept
test reload
wgt 0 12 00 00 00 01 01 00 00 00 ff ff ff ff
run 4 3 0 0 00000004 00000001 0000005a

//--- flist.f
dense_pkg.sv
operand_ram.sv
dense_controller.sv
mac_accumulator.sv
dense_engine.sv
dense_engine_assertions.sv
tb_dense_engine.sv

//--- Bender.yml
package:
  name: dense_engine

sources:
  - dense_pkg.sv
  - operand_ram.sv
  - dense_controller.sv
  - mac_accumulator.sv
  - dense_engine.sv
  - target: test
    files:
      - dense_engine_assertions.sv
      - tb_dense_engine.sv

//--- tb_dense_engine.sv
module tb_dense_engine import dense_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int MAX_IN        = 16;
localparam int MAX_OUT       = 8;
localparam int WGT_DEPTH     = MAX_IN * MAX_OUT;
localparam int RUN_TIMEOUT   = WGT_DEPTH + 32;  // Longest run plus pipeline drain
localparam int RESTART_CYCLE = 3;               // Extra start lands here in mid-run

// ==================================================
// DUT signals
// ==================================================

logic                           clk = 1'b0;
logic                           reset;
logic                           load_we;
load_target_t                   load_target;
logic [$clog2(WGT_DEPTH)-1:0]   load_addr;
acc_t                           load_data;
logic                           start;
logic [$clog2(MAX_IN+1)-1:0]    input_size;
logic [$clog2(MAX_OUT+1)-1:0]   output_size;
act_mode_t                      act_mode;
logic                           busy;
logic                           result_valid;
logic [$clog2(MAX_OUT)-1:0]     result_channel;
acc_t                           result_data;
logic                           done;

string       test_name = "none";
logic [31:0] rng_state = 32'heeb8_0e55;    // LCG state for the memory fill
acc_t        expected [MAX_OUT];            // Expected result per channel
int          fd;                            // Test file handle
int          runs_done = 0;

dense_engine #(
    .MAX_INPUTS(MAX_IN)
    ,.MAX_OUTPUTS(MAX_OUT)
) dut0 (
    .clk(clk)
    ,.reset(reset)
    ,.load_we(load_we)
    ,.load_target(load_target)
    ,.load_addr(load_addr)
    ,.load_data(load_data)
    ,.start(start)
    ,.input_size(input_size)
    ,.output_size(output_size)
    ,.act_mode(act_mode)
    ,.busy(busy)
    ,.result_valid(result_valid)
    ,.result_channel(result_channel)
    ,.result_data(result_data)
    ,.done(done)
);

always #20 clk = ~clk;  // 40 ns period

// ==================================================
// Helpers
// ==================================================

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic stop_with_error(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Stopped in test %s", test_name);
endtask

task automatic check_value(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    if (exp_val !== act_val) begin
        stop_with_error($sformatf("MISMATCH test %s %s expected %h actual %h",
                                  test_name, what, exp_val, act_val));
    end
endtask

// Stop at the first failed assertion of the bound checker
always @(dut0.asserts0.fail_count) begin
    if (dut0.asserts0.fail_count != 0) begin
        stop_with_error("Protocol assertion failed in dense_engine");
    end
end

// One load port write that is held until the next drive
task automatic write_word(input load_target_t target, input int addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    load_we     = 1'b1;
    load_target = target;
    load_addr   = addr;
    load_data   = data;
endtask

// Random values everywhere before the test loads the entries it uses
task automatic fill_memories();
    for (int k = 0; k < MAX_IN; k++) begin
        rng_state = lcg_next(rng_state);
        write_word(LOAD_ACT, k, rng_state);
    end
    for (int k = 0; k < WGT_DEPTH; k++) begin
        rng_state = lcg_next(rng_state);
        write_word(LOAD_WEIGHT, k, rng_state);
    end
    for (int k = 0; k < MAX_OUT; k++) begin
        rng_state = lcg_next(rng_state);
        write_word(LOAD_BIAS, k, rng_state);
    end
endtask

// Base address, count, then count hex values at consecutive addresses
task automatic load_block(input load_target_t target);
    int          base;
    int          count;
    int          n;
    logic [31:0] value;
    n = $fscanf(fd, "%d %d", base, count);
    if (n != 2) stop_with_error("Load line in dense_tests.txt lacks base and count");
    for (int k = 0; k < count; k++) begin
        n = $fscanf(fd, "%h", value);
        if (n != 1) stop_with_error("Load line in dense_tests.txt has too few values");
        write_word(target, base + k, value);
    end
endtask

// ==================================================
// Run and check one layer
// ==================================================

task automatic run_and_check();
    int          in_size;
    int          out_size;
    int          mode;
    int          restart;
    int          n;
    int          cycles;
    int          count;
    int          last_cycle;
    logic [31:0] value;
    bit          finished;
    n = $fscanf(fd, "%d %d %d %d", in_size, out_size, mode, restart);
    if (n != 4) stop_with_error("Run line in dense_tests.txt is incomplete");
    for (int k = 0; k < out_size; k++) begin
        n = $fscanf(fd, "%h", value);
        if (n != 1) stop_with_error("Run line in dense_tests.txt lacks expected results");
        expected[k] = value;
    end
    check_value("busy before start", 0, busy);

    @(posedge clk);
    #2;
    load_we     = 1'b0;   // Last load already taken at this edge
    start       = 1'b1;
    input_size  = in_size;
    output_size = out_size;
    act_mode    = act_mode_t'(mode);

    cycles     = 0;
    count      = 0;
    last_cycle = 0;
    finished   = 1'b0;
    while (!finished) begin
        @(posedge clk);
        #2;
        if (restart != 0 && cycles == RESTART_CYCLE) begin
            start       = 1'b1;     // Must be ignored while the engine is busy
            input_size  = 1;
            output_size = 1;
            act_mode    = act_mode_t'(~mode[0]);
        end else begin
            start = 1'b0;
        end
        @(negedge clk);                 // Outputs settled mid-cycle
        cycles++;
        if (result_valid) begin
            if (count >= out_size) stop_with_error("More results than output channels");
            check_value("result_channel", count, result_channel);
            check_value($sformatf("result_data ch%0d", count), expected[count], result_data);
            count++;
            last_cycle = cycles;
        end
        if (done) begin
            check_value("result count at done", out_size, count);
            check_value("cycles from last result to done", 1, cycles - last_cycle);
            check_value("busy with done", 0, busy);
            finished = 1'b1;
        end else if (cycles > RUN_TIMEOUT) begin
            stop_with_error("Timeout waiting for done at the end of a run");
        end
    end

    @(negedge clk);
    check_value("busy after done", 0, busy);
    check_value("done pulse width", 0, done);
    runs_done++;
endtask

// ==================================================
// Main sequence
// ==================================================

initial begin
    string cmd;
    string comment;
    int    n;
    reset       = 1'b1;
    load_we     = 1'b0;
    load_target = LOAD_ACT;
    load_addr   = '0;
    load_data   = '0;
    start       = 1'b0;
    input_size  = '0;
    output_size = '0;
    act_mode    = ACT_NONE;

    fd = $fopen("dense_tests.txt", "r");
    if (fd == 0) stop_with_error("Could not open dense_tests.txt");

    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd == "#") begin
            n = $fgets(comment, fd);    // Rest of a comment line
        end else if (cmd == "test") begin
            n = $fscanf(fd, "%s", test_name);
        end else if (cmd == "fill") begin
            fill_memories();
        end else if (cmd == "act") begin
            load_block(LOAD_ACT);
        end else if (cmd == "wgt") begin
            load_block(LOAD_WEIGHT);
        end else if (cmd == "bias") begin
            load_block(LOAD_BIAS);
        end else if (cmd == "run") begin
            run_and_check();
        end else begin
            stop_with_error($sformatf("Unknown command %s in dense_tests.txt", cmd));
        end
    end
    $fclose(fd);
    if (runs_done == 0) stop_with_error("No run found in dense_tests.txt");

    if (dut0.asserts0.fail_count == 0) begin
        $display("Finished with no errors");
        $finish;
    end else begin
        stop_with_error($sformatf("%0d assertion failures during the run",
                                  dut0.asserts0.fail_count));
    end
end

endmodule

//--- dense_engine_assertions.sv
module dense_engine_assertions (
    input  logic clk
    ,input  logic reset
    ,input  logic load_we
    ,input  logic busy
    ,input  logic result_valid
    ,input  logic done
);

timeunit 1ns;
timeprecision 100ps;

int fail_count = 0;     // Failures so far

// ==================================================
// Protocol rules of dense_engine
// ==================================================

// Memories are read every cycle of a run
no_load_while_busy: assert property (@(posedge clk) disable iff (reset) busy |-> !load_we)
    else begin
        fail_count++;
        $error("Load port written while the engine is busy");
    end

done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
        fail_count++;
        $error("done stayed high for more than one cycle");
    end

// Last result lands in the final FLUSH cycle
valid_only_busy: assert property (@(posedge clk) disable iff (reset) result_valid |-> busy)
    else begin
        fail_count++;
        $error("result_valid high while the engine is idle");
    end

outputs_low_after_reset: assert property (@(posedge clk)
        reset |=> (!busy && !result_valid && !done))
    else begin
        fail_count++;
        $error("busy, result_valid or done not low after reset");
    end

endmodule

bind dense_engine dense_engine_assertions asserts0 (
    .clk(clk)
    ,.reset(reset)
    ,.load_we(load_we)
    ,.busy(busy)
    ,.result_valid(result_valid)
    ,.done(done)
);

//--- dense_engine.sv
module dense_engine import dense_pkg::*; #(
    parameter int MAX_INPUTS   = DEFAULT_MAX_INPUTS
    ,parameter int MAX_OUTPUTS = DEFAULT_MAX_OUTPUTS
)
(
    input  logic clk
    ,input  logic reset

    // Load port, writes land in the cycle load_we is high
    ,input  logic                                       load_we
    ,input  load_target_t                               load_target
    ,input  logic [$clog2(MAX_INPUTS*MAX_OUTPUTS)-1:0]  load_addr
    ,input  acc_t                                       load_data   // Low byte for act/weight

    // Run port
    ,input  logic                                       start
    ,input  logic [$clog2(MAX_INPUTS+1)-1:0]            input_size
    ,input  logic [$clog2(MAX_OUTPUTS+1)-1:0]           output_size
    ,input  act_mode_t                                  act_mode

    // Results, one per output channel
    ,output logic                                       busy
    ,output logic                                       result_valid
    ,output logic [$clog2(MAX_OUTPUTS)-1:0]             result_channel
    ,output acc_t                                       result_data
    ,output logic                                       done
);

localparam int IN_AW  = $clog2(MAX_INPUTS);
localparam int OUT_AW = $clog2(MAX_OUTPUTS);
localparam int WGT_AW = $clog2(MAX_INPUTS * MAX_OUTPUTS);

// ==================================================
// Load decode and run configuration
// ==================================================

logic      act_we;
logic      wgt_we;
logic      bias_we;
act_mode_t act_mode_q;  // Held for the whole run

assign act_we  = load_we && (load_target == LOAD_ACT);
assign wgt_we  = load_we && (load_target == LOAD_WEIGHT);
assign bias_we = load_we && (load_target == LOAD_BIAS);

// Same acceptance rule as the controller FSM
always_ff @(posedge clk) begin
    if (reset) begin
        act_mode_q <= ACT_NONE;
    end else if (start && !busy) begin
        act_mode_q <= act_mode;
    end
end

// ==================================================
// Controller
// ==================================================

logic              rd_en;
logic [IN_AW-1:0]  act_rd_addr;
logic [WGT_AW-1:0] wgt_rd_addr;
logic [OUT_AW-1:0] bias_rd_addr;
logic              mac_first;
logic              mac_last;
logic [OUT_AW-1:0] mac_channel;

dense_controller #(
    .MAX_INPUTS(MAX_INPUTS)
    ,.MAX_OUTPUTS(MAX_OUTPUTS)
) controller0 (
    .clk(clk)
    ,.reset(reset)
    ,.start(start)
    ,.input_size(input_size)
    ,.output_size(output_size)
    ,.busy(busy)
    ,.done(done)
    ,.act_rd_en(rd_en)
    ,.act_rd_addr(act_rd_addr)
    ,.wgt_rd_addr(wgt_rd_addr)
    ,.bias_rd_addr(bias_rd_addr)
    ,.mac_first(mac_first)
    ,.mac_last(mac_last)
    ,.mac_channel(mac_channel)
);

// ==================================================
// Operand memories
// ==================================================

act_t act_rdata;
act_t wgt_rdata;
acc_t bias_rdata;

operand_ram #(.WIDTH(8), .DEPTH(MAX_INPUTS)) act_ram0 (     // Activation vector
    .clk(clk)
    ,.we(act_we)
    ,.waddr(load_addr[IN_AW-1:0])
    ,.wdata(load_data[7:0])
    ,.re(rd_en)
    ,.raddr(act_rd_addr)
    ,.rdata(act_rdata)
);

operand_ram #(.WIDTH(8), .DEPTH(MAX_INPUTS * MAX_OUTPUTS)) wgt_ram0 (  // Row per channel
    .clk(clk)
    ,.we(wgt_we)
    ,.waddr(load_addr)
    ,.wdata(load_data[7:0])
    ,.re(rd_en)
    ,.raddr(wgt_rd_addr)
    ,.rdata(wgt_rdata)
);

operand_ram #(.WIDTH(32), .DEPTH(MAX_OUTPUTS)) bias_ram0 (  // One int32 per channel
    .clk(clk)
    ,.we(bias_we)
    ,.waddr(load_addr[OUT_AW-1:0])
    ,.wdata(load_data)
    ,.re(rd_en)
    ,.raddr(bias_rd_addr)
    ,.rdata(bias_rdata)
);

// ==================================================
// MAC
// ==================================================

mac_accumulator #(
    .MAX_OUTPUTS(MAX_OUTPUTS)
) mac0 (
    .clk(clk)
    ,.reset(reset)
    ,.act_mode(act_mode_q)
    ,.act_data(act_rdata)
    ,.wgt_data(wgt_rdata)
    ,.bias_data(bias_rdata)
    ,.first(mac_first)
    ,.last(mac_last)
    ,.channel(mac_channel)
    ,.result_valid(result_valid)
    ,.result_channel(result_channel)
    ,.result_data(result_data)
);

endmodule

//--- mac_accumulator.sv
module mac_accumulator import dense_pkg::*; #(
    parameter int MAX_OUTPUTS = DEFAULT_MAX_OUTPUTS
)
(
    input  logic clk
    ,input  logic reset

    ,input  act_mode_t                          act_mode

    // Operands straight from the RAM read ports
    ,input  act_t                               act_data
    ,input  act_t                               wgt_data
    ,input  acc_t                               bias_data

    // Tags from the controller, one cycle ahead of the data
    ,input  logic                               first
    ,input  logic                               last
    ,input  logic [$clog2(MAX_OUTPUTS)-1:0]     channel

    ,output logic                               result_valid
    ,output logic [$clog2(MAX_OUTPUTS)-1:0]     result_channel
    ,output acc_t                               result_data
);

localparam int CH_W = $clog2(MAX_OUTPUTS);

logic            first_d;       // Tags aligned with RAM data
logic            last_d;
logic [CH_W-1:0] channel_d;

acc_t acc_q;        // Running sum
acc_t product;      // Signed int8 x int8
acc_t sum_next;
acc_t activated;    // Sum after optional ReLU

// Match the one-cycle RAM read latency
always_ff @(posedge clk) begin
    if (reset) begin
        first_d <= 1'b0;
        last_d  <= 1'b0;
    end else begin
        first_d <= first;
        last_d  <= last;
    end
end

always_ff @(posedge clk) begin
    channel_d <= channel;
end

// Sign extend both operands before the multiply
assign product = acc_t'(act_data) * acc_t'(wgt_data);

// First element starts from the bias instead of the old sum
assign sum_next = first_d ? (bias_data + product) : (acc_q + product);

assign activated = (act_mode == ACT_RELU && sum_next < 0) ? '0 : sum_next;

// Free-running, every channel restarts on first
always_ff @(posedge clk) begin
    acc_q <= sum_next;
end

// ==================================================
// Result register
// ==================================================

always_ff @(posedge clk) begin
    if (reset) begin
        result_valid <= 1'b0;
    end else begin
        result_valid <= last_d;     // One strobe per channel
    end
end

always_ff @(posedge clk) begin
    if (last_d) begin
        result_data    <= activated;
        result_channel <= channel_d;
    end
end

endmodule

//--- dense_controller.sv
module dense_controller import dense_pkg::*; #(
    parameter int MAX_INPUTS   = DEFAULT_MAX_INPUTS
    ,parameter int MAX_OUTPUTS = DEFAULT_MAX_OUTPUTS
)
(
    input  logic clk
    ,input  logic reset

    // Run request, sizes sampled on an accepted start
    ,input  logic                                 start
    ,input  logic [$clog2(MAX_INPUTS+1)-1:0]      input_size
    ,input  logic [$clog2(MAX_OUTPUTS+1)-1:0]     output_size

    ,output logic                                 busy
    ,output logic                                 done

    // Read side of the three operand RAMs
    ,output logic                                 act_rd_en    // Shared by all three RAMs
    ,output logic [$clog2(MAX_INPUTS)-1:0]        act_rd_addr
    ,output logic [$clog2(MAX_INPUTS*MAX_OUTPUTS)-1:0] wgt_rd_addr
    ,output logic [$clog2(MAX_OUTPUTS)-1:0]       bias_rd_addr

    // Tags for the MAC, issued alongside the reads
    ,output logic                                 mac_first
    ,output logic                                 mac_last
    ,output logic [$clog2(MAX_OUTPUTS)-1:0]       mac_channel
);

localparam int IN_AW  = $clog2(MAX_INPUTS);
localparam int OUT_AW = $clog2(MAX_OUTPUTS);
localparam int WGT_AW = $clog2(MAX_INPUTS * MAX_OUTPUTS);
localparam int IN_SW  = $clog2(MAX_INPUTS + 1);    // Size fields hold the full count
localparam int OUT_SW = $clog2(MAX_OUTPUTS + 1);

// ==================================================
// State and counters
// ==================================================

ctrl_state_t        state;
logic [IN_SW-1:0]   in_size_q;      // Latched input_size
logic [OUT_SW-1:0]  out_size_q;     // Latched output_size
logic [IN_AW-1:0]   in_cnt;         // Element index inside the channel
logic [OUT_AW-1:0]  ch_cnt;         // Current output channel
logic [WGT_AW-1:0]  wgt_addr;       // Running o*input_size + i, no multiplier
logic               flush_cnt;      // Counts the two drain cycles

logic in_last;      // Last element of the channel
logic ch_last;      // Last channel of the run

assign in_last = (IN_SW'(in_cnt) == in_size_q - IN_SW'(1));
assign ch_last = (OUT_SW'(ch_cnt) == out_size_q - OUT_SW'(1));

// ==================================================
// Run FSM
// ==================================================

always_ff @(posedge clk) begin
    if (reset) begin
        state      <= IDLE;
        in_size_q  <= '0;
        out_size_q <= '0;
        in_cnt     <= '0;
        ch_cnt     <= '0;
        wgt_addr   <= '0;
        flush_cnt  <= 1'b0;
        done       <= 1'b0;
    end else begin
        done <= 1'b0;   // Single-cycle pulse

        case (state)
            IDLE: begin
                if (start) begin
                    in_size_q  <= input_size;
                    out_size_q <= output_size;
                    in_cnt     <= '0;
                    ch_cnt     <= '0;
                    wgt_addr   <= '0;
                    flush_cnt  <= 1'b0;
                    // Empty run has nothing to read, just close it
                    if (input_size == '0 || output_size == '0) begin
                        state <= FLUSH;
                    end else begin
                        state <= RUN;
                    end
                end
            end

            RUN: begin
                wgt_addr <= wgt_addr + WGT_AW'(1);  // Weights are contiguous per channel
                if (in_last) begin
                    in_cnt <= '0;
                    if (ch_last) begin
                        state <= FLUSH;
                    end else begin
                        ch_cnt <= ch_cnt + OUT_AW'(1);  // Next channel, no bubble
                    end
                end else begin
                    in_cnt <= in_cnt + IN_AW'(1);
                end
            end

            FLUSH: begin
                // RAM read stage plus MAC result stage
                flush_cnt <= ~flush_cnt;
                if (flush_cnt) begin
                    state <= IDLE;  // busy drops with done
                    done  <= 1'b1;
                end
            end

            default: state <= IDLE;
        endcase
    end
end

// ==================================================
// Outputs
// ==================================================

assign busy = (state != IDLE);

assign act_rd_en    = (state == RUN);
assign act_rd_addr  = in_cnt;
assign wgt_rd_addr  = wgt_addr;
assign bias_rd_addr = ch_cnt;           // Stays put for the whole channel

// Channel boundaries, only meaningful while reading
assign mac_first   = (state == RUN) && (in_cnt == '0);
assign mac_last    = (state == RUN) && in_last;
assign mac_channel = ch_cnt;

endmodule

//--- operand_ram.sv
module operand_ram #(
    parameter int WIDTH  = 8
    ,parameter int DEPTH = 256
)
(
    input  logic                     clk

    // Write side, fed by the load port
    ,input  logic                     we
    ,input  logic [$clog2(DEPTH)-1:0] waddr
    ,input  logic [WIDTH-1:0]         wdata

    // Read side, driven by the controller
    ,input  logic                     re
    ,input  logic [$clog2(DEPTH)-1:0] raddr
    ,output logic [WIDTH-1:0]         rdata
);

logic [WIDTH-1:0] mem [DEPTH];  // Storage array

// Single write port
always_ff @(posedge clk) begin
    if (we) begin
        mem[waddr] <= wdata;
    end
end

// Registered read, one cycle of latency
// Data holds its last value while re is low
always_ff @(posedge clk) begin
    if (re) begin
        rdata <= mem[raddr];
    end
end

endmodule

//--- dense_pkg.sv
package dense_pkg;

// ==================================================
// Data types
// ==================================================

typedef logic signed [7:0]  act_t;  // One int8 activation or weight element
typedef logic signed [31:0] acc_t;  // Bias, running sum and result

// ==================================================
// Enums
// ==================================================

// Run FSM of the controller
typedef enum logic [1:0] {
    IDLE   = 2'd0   // Waiting for start
    ,RUN   = 2'd1   // One read per cycle across all channels
    ,FLUSH = 2'd2   // Draining RAM and MAC stages
} ctrl_state_t;

// Memory written by the load port
typedef enum logic [1:0] {
    LOAD_ACT     = 2'd0
    ,LOAD_WEIGHT = 2'd1
    ,LOAD_BIAS   = 2'd2
} load_target_t;

// Output activation applied to each channel result
typedef enum logic {
    ACT_NONE  = 1'b0    // Pass signed sum through
    ,ACT_RELU = 1'b1    // Clamp negatives to zero
} act_mode_t;

// ==================================================
// Default capacities
// ==================================================

localparam int DEFAULT_MAX_INPUTS  = 256;   // Flattened input vector length
localparam int DEFAULT_MAX_OUTPUTS = 64;    // Output channels

endpackage
